//--- logic/ln_geom_pkg.sv
package ln_geom_pkg;

    // beat and vector shape
    localparam int LANES = 8;
    localparam int VEC_BEATS = 8;
    localparam int ELEM_W = 8;
    localparam int BEAT_W = LANES * ELEM_W;
    localparam int BEAT_IDX_W = $clog2(VEC_BEATS);

    // mean is a plain shift since the vector length is fixed
    localparam int MEAN_SHIFT = $clog2(LANES * VEC_BEATS);
    localparam int SUM_W = 16;

    // width growth through one lane reduction
    localparam int TREE_GROW = $clog2(LANES);

    // a square of -128 is +16384, which needs a spare sign bit on a signed lane
    localparam int SQ_W = 16;
    localparam int VAR_W = 24;

    typedef logic signed [ELEM_W-1:0] elem_t;

    // buffer keeps the flat word, datapath reads lanes
    typedef union packed {
        logic [BEAT_W-1:0]       flat;
        elem_t [LANES-1:0]       lanes;
    } beat_u;

endpackage

//--- logic/ln_flow_pkg.sv
package ln_flow_pkg;

    // one full vector of buffer slots
    localparam int IN_CREDITS = ln_geom_pkg::VEC_BEATS;
    localparam int IN_CRED_W = $clog2(IN_CREDITS + 1);

    // granted by the downstream at reset
    localparam int OUT_CREDITS = 4;
    localparam int OUT_CRED_W = $clog2(OUT_CREDITS + 1);

    // input regs plus one more register stage for 8 lanes
    localparam int TREE_LAT = 2;

endpackage

//--- logic/beat_buffer.sv
`timescale 1ns/1ps

module beat_buffer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               wr_en,
    input  ln_geom_pkg::beat_u wr_data,
    input  logic               rd_en,
    output ln_geom_pkg::beat_u rd_data,
    output logic               in_credit
);

    logic [ln_geom_pkg::BEAT_W-1:0]     mem [ln_geom_pkg::VEC_BEATS];
    logic [ln_geom_pkg::BEAT_IDX_W-1:0] wr_ptr;
    logic [ln_geom_pkg::BEAT_IDX_W-1:0] rd_ptr;
    logic [ln_flow_pkg::IN_CRED_W-1:0]  granted;
    logic                               burst;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data.flat;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ln_geom_pkg::BEAT_IDX_W'(ln_geom_pkg::VEC_BEATS - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ln_geom_pkg::BEAT_IDX_W'(ln_geom_pkg::VEC_BEATS - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
        end
    end

    assign rd_data.flat = mem[rd_ptr];

    // initial grant, one slot per cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            granted <= '0;
            burst   <= 1'b0;
        end else if (granted != ln_flow_pkg::IN_CRED_W'(ln_flow_pkg::IN_CREDITS)) begin
            granted <= granted + 1'b1;
            burst   <= 1'b1;
        end else begin
            burst   <= 1'b0;
        end
    end

    // a read frees its slot right away
    assign in_credit = burst | rd_en;

endmodule

//--- logic/lane_adder_tree.sv
`timescale 1ns/1ps

module lane_adder_tree #(
    parameter int in_w = 8
) (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  logic signed [ln_geom_pkg::LANES-1:0][in_w-1:0]   lanes_in,
    input  logic                                             in_vld,
    output logic signed [in_w+ln_geom_pkg::TREE_GROW-1:0]    sum,
    output logic                                             sum_vld
);

    localparam int STAGES = ln_geom_pkg::TREE_GROW;

    genvar s;
    generate
        for (s = 0; s < STAGES; s++) begin : g_stage
            localparam int IW = in_w + s;
            localparam int N = ln_geom_pkg::LANES >> s;

            logic signed [IW-1:0] op  [N];
            logic signed [IW:0]   res [N/2];
            logic                 vld;

            if (s == 0) begin : g_in
                always_ff @(posedge clk or negedge rstn) begin
                    if (!rstn) begin
                        vld <= 1'b0;
                    end else begin
                        vld <= in_vld;
                    end
                end

                always_ff @(posedge clk) begin
                    if (in_vld) begin
                        for (int k = 0; k < N; k++) begin
                            op[k] <= lanes_in[k];
                        end
                    end
                end
            end else if (s % 2 == 0) begin : g_reg
                // even stages break the carry chain
                always_ff @(posedge clk or negedge rstn) begin
                    if (!rstn) begin
                        vld <= 1'b0;
                    end else begin
                        vld <= g_stage[s-1].vld;
                    end
                end

                always_ff @(posedge clk) begin
                    if (g_stage[s-1].vld) begin
                        for (int k = 0; k < N; k++) begin
                            op[k] <= g_stage[s-1].res[k];
                        end
                    end
                end
            end else begin : g_comb
                assign vld = g_stage[s-1].vld;

                always_comb begin
                    for (int k = 0; k < N; k++) begin
                        op[k] = g_stage[s-1].res[k];
                    end
                end
            end

            // pairwise add, one bit of growth
            always_comb begin
                for (int k = 0; k < N / 2; k++) begin
                    res[k] = op[2*k] + op[2*k+1];
                end
            end
        end
    endgenerate

    assign sum     = g_stage[STAGES-1].res[0];
    assign sum_vld = g_stage[STAGES-1].vld;

endmodule

//--- logic/mean_unit.sv
`timescale 1ns/1ps

module mean_unit (
    input  logic                                                        clk,
    input  logic                                                        rstn,
    input  logic signed [ln_geom_pkg::ELEM_W+ln_geom_pkg::TREE_GROW-1:0] sum,
    input  logic                                                        sum_vld,
    output logic signed [ln_geom_pkg::ELEM_W-1:0]                       mean,
    output logic                                                        mean_vld
);

    logic signed [ln_geom_pkg::SUM_W-1:0] acc;
    logic signed [ln_geom_pkg::SUM_W-1:0] acc_next;
    logic signed [ln_geom_pkg::SUM_W-1:0] shifted;
    logic [ln_geom_pkg::BEAT_IDX_W-1:0]   beat_cnt;
    logic                                 last_beat;

    assign acc_next  = acc + ln_geom_pkg::SUM_W'(sum);
    // floor division by the element count
    assign shifted   = acc_next >>> ln_geom_pkg::MEAN_SHIFT;
    assign last_beat = (beat_cnt == ln_geom_pkg::BEAT_IDX_W'(ln_geom_pkg::VEC_BEATS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc      <= '0;
            beat_cnt <= '0;
            mean_vld <= 1'b0;
        end else begin
            mean_vld <= sum_vld & last_beat;
            if (sum_vld) begin
                acc      <= last_beat ? '0 : acc_next;
                beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sum_vld && last_beat) begin
            mean <= shifted[ln_geom_pkg::ELEM_W-1:0];
        end
    end

endmodule

//--- logic/center_unit.sv
`timescale 1ns/1ps

module center_unit (
    input  logic                                                         clk,
    input  logic                                                         rstn,
    input  logic signed [ln_geom_pkg::ELEM_W-1:0]                        mean,
    input  logic                                                         mean_vld,
    input  ln_geom_pkg::beat_u                                           rd_data,
    output logic                                                         rd_en,
    input  logic                                                         out_credit,
    output ln_geom_pkg::beat_u                                           out_data,
    output logic                                                         out_vld,
    output logic                                                         out_last,
    output logic signed [ln_geom_pkg::LANES-1:0][ln_geom_pkg::SQ_W-1:0]  sq_lanes,
    output logic                                                         sq_vld,
    output logic                                                         vec_end
);

    logic signed [ln_geom_pkg::ELEM_W-1:0] mean_q;
    logic                                  active;
    logic [ln_geom_pkg::BEAT_IDX_W-1:0]    beat_idx;
    logic [ln_flow_pkg::OUT_CRED_W-1:0]    credits;
    logic                                  last_beat;
    ln_geom_pkg::elem_t                    centered [ln_geom_pkg::LANES];

    // clamp a one bit wider difference back to the element range
    function automatic ln_geom_pkg::elem_t sat_elem(
        input logic signed [ln_geom_pkg::ELEM_W:0] d
    );
        ln_geom_pkg::elem_t r;
        if (d[ln_geom_pkg::ELEM_W] != d[ln_geom_pkg::ELEM_W-1]) begin
            r = d[ln_geom_pkg::ELEM_W] ? {1'b1, {(ln_geom_pkg::ELEM_W-1){1'b0}}} :
                                         {1'b0, {(ln_geom_pkg::ELEM_W-1){1'b1}}};
        end else begin
            r = d[ln_geom_pkg::ELEM_W-1:0];
        end
        return r;
    endfunction

    assign rd_en     = active && (credits != '0);
    assign last_beat = (beat_idx == ln_geom_pkg::BEAT_IDX_W'(ln_geom_pkg::VEC_BEATS - 1));

    always_comb begin
        for (int k = 0; k < ln_geom_pkg::LANES; k++) begin
            centered[k] = sat_elem((ln_geom_pkg::ELEM_W+1)'(rd_data.lanes[k]) -
                                   (ln_geom_pkg::ELEM_W+1)'(mean_q));
        end
    end

    // drain control
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            active   <= 1'b0;
            beat_idx <= '0;
        end else begin
            if (rd_en) begin
                beat_idx <= last_beat ? '0 : beat_idx + 1'b1;
                if (last_beat) begin
                    active <= 1'b0;
                end
            end
            if (mean_vld) begin
                active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mean_vld) begin
            mean_q <= mean;
        end
    end

    // a read commits one out_vld beat, so it spends the credit
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits <= ln_flow_pkg::OUT_CRED_W'(ln_flow_pkg::OUT_CREDITS);
        end else begin
            case ({out_credit, rd_en})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_vld  <= 1'b0;
            out_last <= 1'b0;
        end else begin
            out_vld  <= rd_en;
            out_last <= rd_en & last_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int k = 0; k < ln_geom_pkg::LANES; k++) begin
                out_data.lanes[k] <= centered[k];
                sq_lanes[k]       <= centered[k] * centered[k];
            end
        end
    end

    // squares leave together with the output beat
    assign sq_vld  = out_vld;
    assign vec_end = out_last;

endmodule

//--- logic/variance_unit.sv
`timescale 1ns/1ps

module variance_unit (
    input  logic                                                       clk,
    input  logic                                                       rstn,
    input  logic signed [ln_geom_pkg::SQ_W+ln_geom_pkg::TREE_GROW-1:0] sum,
    input  logic                                                       sum_vld,
    input  logic                                                       vec_end,
    output logic [ln_geom_pkg::VAR_W-1:0]                              var_sum,
    output logic                                                       var_vld
);

    logic [ln_geom_pkg::VAR_W-1:0]      acc;
    logic [ln_geom_pkg::VAR_W-1:0]      acc_next;
    logic [ln_flow_pkg::TREE_LAT-1:0]   end_pipe;
    logic                               end_here;

    assign acc_next = acc + ln_geom_pkg::VAR_W'(sum);

    // vec_end rides alongside the tree latency
    assign end_here = end_pipe[ln_flow_pkg::TREE_LAT-1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            end_pipe <= '0;
            acc      <= '0;
            var_vld  <= 1'b0;
        end else begin
            end_pipe <= {end_pipe[ln_flow_pkg::TREE_LAT-2:0], vec_end};
            var_vld  <= sum_vld & end_here;
            if (sum_vld) begin
                acc <= end_here ? '0 : acc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sum_vld && end_here) begin
            var_sum <= acc_next;
        end
    end

endmodule

//--- logic/ln_top.sv
`timescale 1ns/1ps

module ln_top (
    input  logic                            clk,
    input  logic                            rstn,
    input  ln_geom_pkg::beat_u              in_data,
    input  logic                            in_vld,
    output logic                            in_credit,
    output ln_geom_pkg::beat_u              out_data,
    output logic                            out_vld,
    output logic                            out_last,
    input  logic                            out_credit,
    output logic [ln_geom_pkg::VAR_W-1:0]   var_sum,
    output logic                            var_vld
);

    ln_geom_pkg::beat_u                                                 rd_data;
    logic                                                               rd_en;
    logic signed [ln_geom_pkg::ELEM_W+ln_geom_pkg::TREE_GROW-1:0]       beat_sum;
    logic                                                               beat_sum_vld;
    logic signed [ln_geom_pkg::ELEM_W-1:0]                              mean;
    logic                                                               mean_vld;
    logic signed [ln_geom_pkg::LANES-1:0][ln_geom_pkg::SQ_W-1:0]        sq_lanes;
    logic                                                               sq_vld;
    logic                                                               vec_end;
    logic signed [ln_geom_pkg::SQ_W+ln_geom_pkg::TREE_GROW-1:0]         sq_sum;
    logic                                                               sq_sum_vld;

    beat_buffer u_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .wr_en     (in_vld),
        .wr_data   (in_data),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .in_credit (in_credit)
    );

    lane_adder_tree #(.in_w(ln_geom_pkg::ELEM_W)) sum_tree (
        .clk      (clk),
        .rstn     (rstn),
        .lanes_in (in_data.lanes),
        .in_vld   (in_vld),
        .sum      (beat_sum),
        .sum_vld  (beat_sum_vld)
    );

    mean_unit u_mean (
        .clk      (clk),
        .rstn     (rstn),
        .sum      (beat_sum),
        .sum_vld  (beat_sum_vld),
        .mean     (mean),
        .mean_vld (mean_vld)
    );

    center_unit u_center (
        .clk        (clk),
        .rstn       (rstn),
        .mean       (mean),
        .mean_vld   (mean_vld),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .out_credit (out_credit),
        .out_data   (out_data),
        .out_vld    (out_vld),
        .out_last   (out_last),
        .sq_lanes   (sq_lanes),
        .sq_vld     (sq_vld),
        .vec_end    (vec_end)
    );

    lane_adder_tree #(.in_w(ln_geom_pkg::SQ_W)) sq_tree (
        .clk      (clk),
        .rstn     (rstn),
        .lanes_in (sq_lanes),
        .in_vld   (sq_vld),
        .sum      (sq_sum),
        .sum_vld  (sq_sum_vld)
    );

    variance_unit u_var (
        .clk     (clk),
        .rstn    (rstn),
        .sum     (sq_sum),
        .sum_vld (sq_sum_vld),
        .vec_end (vec_end),
        .var_sum (var_sum),
        .var_vld (var_vld)
    );

endmodule

//--- bench/ln_checker.sv
`timescale 1ns/1ps

module ln_checker (
    input  logic                          clk,
    input  logic                          rstn,
    input  ln_geom_pkg::beat_u            in_data,
    input  logic                          in_vld,
    input  logic                          in_credit,
    input  ln_geom_pkg::beat_u            out_data,
    input  logic                          out_vld,
    input  logic                          out_last,
    input  logic                          out_credit,
    input  logic [ln_geom_pkg::VAR_W-1:0] var_sum,
    input  logic                          var_vld,
    input  logic                          done,
    output int                            err_count,
    output int                            check_count,
    output int                            vec_count,
    output logic                          closed
);

    localparam int EW = ln_geom_pkg::ELEM_W;
    localparam int VB = ln_geom_pkg::VEC_BEATS;
    localparam int ELEMS = ln_geom_pkg::LANES * VB;
    localparam int ELEM_MAX = (1 << (EW - 1)) - 1;
    localparam int ELEM_MIN = -(1 << (EW - 1));

    logic [ln_geom_pkg::BEAT_W-1:0] sent [$];
    int     var_due [$];
    longint var_exp [$];
    int     err_base_q [$];
    longint var_acc;
    int     mean_ref;
    int     err_base;
    int     out_beats;
    int     credits_seen;
    int     outstanding;
    int     cycle;

    function automatic int lane_val(input logic [ln_geom_pkg::BEAT_W-1:0] w, input int k);
        logic signed [EW-1:0] e;
        e = w[k*EW +: EW];
        return int'(e);
    endfunction

    // mean rounds toward minus infinity
    function automatic int floor_mean(input int total);
        if (total >= 0) begin
            return total / ELEMS;
        end
        return -((-total + ELEMS - 1) / ELEMS);
    endfunction

    function automatic int clamp_elem(input int v);
        if (v > ELEM_MAX) begin
            return ELEM_MAX;
        end
        if (v < ELEM_MIN) begin
            return ELEM_MIN;
        end
        return v;
    endfunction

    task automatic flag_error(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    task automatic check_beat();
        int v;
        int b;
        int total;
        int d;
        logic [ln_geom_pkg::BEAT_W-1:0] exp_word;
        v = out_beats / VB;
        b = out_beats % VB;
        if (b == 0) begin
            err_base = err_count;
        end
        if (sent.size() < (v + 1) * VB) begin
            flag_error($sformatf("beat %0d of vector %0d came out before it was sent", b, v));
        end else begin
            if (b == 0) begin
                total = 0;
                for (int i = 0; i < VB; i++) begin
                    for (int k = 0; k < ln_geom_pkg::LANES; k++) begin
                        total += lane_val(sent[v*VB+i], k);
                    end
                end
                mean_ref = floor_mean(total);
                var_acc = 0;
            end
            exp_word = '0;
            for (int k = 0; k < ln_geom_pkg::LANES; k++) begin
                d = clamp_elem(lane_val(sent[v*VB+b], k) - mean_ref);
                exp_word[k*EW +: EW] = d[EW-1:0];
                var_acc += longint'(d * d);
            end
            check_count++;
            if (out_data.flat !== exp_word) begin
                flag_error($sformatf("mismatch out_data vector %0d beat %0d: expected %h, actual %h",
                                     v, b, exp_word, out_data.flat));
            end
        end
        check_count++;
        if (out_last !== 1'(b == VB - 1)) begin
            flag_error($sformatf("mismatch out_last vector %0d beat %0d: expected %h, actual %h",
                                 v, b, 1'(b == VB - 1), out_last));
        end
        if (b == VB - 1) begin
            var_due.push_back(cycle + ln_flow_pkg::TREE_LAT + 1);
            var_exp.push_back(var_acc);
            err_base_q.push_back(err_base);
        end
        out_beats++;
    endtask

    task automatic check_var();
        int due;
        int base;
        logic [ln_geom_pkg::VAR_W-1:0] exp_sum;
        if (var_due.size() == 0) begin
            flag_error("var_vld pulsed with no finished vector");
        end else begin
            due = var_due.pop_front();
            exp_sum = ln_geom_pkg::VAR_W'(var_exp.pop_front());
            base = err_base_q.pop_front();
            check_count++;
            if (cycle != due) begin
                flag_error($sformatf("var_vld came at cycle %0d, expected at cycle %0d", cycle, due));
            end
            check_count++;
            if (var_sum !== exp_sum) begin
                flag_error($sformatf("mismatch var_sum vector %0d: expected %h, actual %h",
                                     vec_count, exp_sum, var_sum));
            end
            $display("vector %0d done, %0d errors", vec_count, err_count - base);
            vec_count++;
        end
    endtask

    task automatic close_run();
        check_count++;
        if (credits_seen != ln_flow_pkg::IN_CREDITS + out_beats) begin
            flag_error($sformatf("in_credit pulsed %0d times, expected %0d", credits_seen,
                                 ln_flow_pkg::IN_CREDITS + out_beats));
        end
        check_count++;
        if (sent.size() != out_beats || var_due.size() != 0) begin
            flag_error($sformatf("%0d beats went in, %0d came out, %0d var_vld still missing",
                                 sent.size(), out_beats, var_due.size()));
        end
        closed = 1'b1;
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            sent.delete();
            var_due.delete();
            var_exp.delete();
            err_base_q.delete();
            err_count = 0;
            check_count = 0;
            vec_count = 0;
            out_beats = 0;
            credits_seen = 0;
            outstanding = 0;
            cycle = 0;
            closed = 1'b0;
        end else begin
            cycle++;
            if (in_vld) begin
                sent.push_back(in_data.flat);
            end
            if (in_credit) begin
                credits_seen++;
            end
            // beats the downstream holds without having returned a credit
            outstanding = outstanding + int'(out_vld) - int'(out_credit);
            if (outstanding > ln_flow_pkg::OUT_CREDITS) begin
                flag_error($sformatf("%0d output beats outstanding, only %0d credits granted",
                                     outstanding, ln_flow_pkg::OUT_CREDITS));
            end
            if (out_vld) begin
                check_beat();
            end
            if (var_vld) begin
                check_var();
            end
            if (done && !closed) begin
                close_run();
            end
        end
    end

endmodule

//--- bench/ln_tb.sv
`timescale 1ns/1ps

module ln_tb;

    localparam int NUM_ROWS = 10;
    localparam int FILL_CONST = 0;
    localparam int FILL_RAND = 1;
    localparam int FILL_EXTREME = 2;

    // per row: fill kind, constant element, cycles before each out_credit goes back
    localparam int ROW_FILL [NUM_ROWS] = '{
        FILL_CONST, FILL_RAND, FILL_EXTREME, FILL_RAND, FILL_RAND,
        FILL_CONST, FILL_RAND, FILL_RAND, FILL_EXTREME, FILL_RAND
    };
    localparam int ROW_VALUE [NUM_ROWS] = '{37, 0, 0, 0, 0, -90, 0, 0, 0, 0};
    localparam int ROW_DELAY [NUM_ROWS] = '{0, 0, 1, 3, 20, 12, 20, 0, 0, 5};

    logic                            clk = 1'b0;
    logic                            rstn = 1'b0;
    ln_geom_pkg::beat_u              in_data = '0;
    logic                            in_vld = 1'b0;
    logic                            in_credit;
    ln_geom_pkg::beat_u              out_data;
    logic                            out_vld;
    logic                            out_last;
    logic                            out_credit = 1'b0;
    logic [ln_geom_pkg::VAR_W-1:0]   var_sum;
    logic                            var_vld;
    logic                            chk_done = 1'b0;
    logic                            closed;
    int                              err_count;
    int                              check_count;
    int                              vec_count;

    logic [15:0] lfsr = 16'd12920;
    int          credits_held = 0;
    int          out_seen = 0;
    int          tick = 0;
    int          credit_due [$];

    always #4 clk = ~clk;

    ln_top DUT (
        .clk        (clk),
        .rstn       (rstn),
        .in_data    (in_data),
        .in_vld     (in_vld),
        .in_credit  (in_credit),
        .out_data   (out_data),
        .out_vld    (out_vld),
        .out_last   (out_last),
        .out_credit (out_credit),
        .var_sum    (var_sum),
        .var_vld    (var_vld)
    );

    ln_checker u_check (
        .clk         (clk),
        .rstn        (rstn),
        .in_data     (in_data),
        .in_vld      (in_vld),
        .in_credit   (in_credit),
        .out_data    (out_data),
        .out_vld     (out_vld),
        .out_last    (out_last),
        .out_credit  (out_credit),
        .var_sum     (var_sum),
        .var_vld     (var_vld),
        .done        (chk_done),
        .err_count   (err_count),
        .check_count (check_count),
        .vec_count   (vec_count),
        .closed      (closed)
    );

    // galois form, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(output logic [ln_geom_pkg::ELEM_W-1:0] v);
        v = '0;
        for (int i = 0; i < ln_geom_pkg::ELEM_W; i++) begin
            v = {v[ln_geom_pkg::ELEM_W-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // waits for a credit in hand, then drives one beat
    task automatic send_beat(input logic [ln_geom_pkg::BEAT_W-1:0] word);
        @(posedge clk);
        in_vld <= 1'b0;
        if (in_credit) begin
            credits_held++;
        end
        while (credits_held == 0) begin
            @(posedge clk);
            if (in_credit) begin
                credits_held++;
            end
        end
        in_vld       <= 1'b1;
        in_data.flat <= word;
        credits_held--;
    endtask

    // downstream returns each credit after the row's delay
    always @(posedge clk) begin
        int row;
        if (!rstn) begin
            out_credit <= 1'b0;
        end else begin
            if (out_vld) begin
                row = out_seen / ln_geom_pkg::VEC_BEATS;
                if (row >= NUM_ROWS) begin
                    row = NUM_ROWS - 1;
                end
                credit_due.push_back(tick + ROW_DELAY[row]);
                out_seen++;
            end
            if (credit_due.size() != 0 && credit_due[0] <= tick) begin
                void'(credit_due.pop_front());
                out_credit <= 1'b1;
            end else begin
                out_credit <= 1'b0;
            end
            tick++;
        end
    end

    initial begin
        logic [ln_geom_pkg::BEAT_W-1:0] word;
        logic [ln_geom_pkg::ELEM_W-1:0] elem;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int b = 0; b < ln_geom_pkg::VEC_BEATS; b++) begin
                for (int k = 0; k < ln_geom_pkg::LANES; k++) begin
                    case (ROW_FILL[r])
                        FILL_CONST: elem = ln_geom_pkg::ELEM_W'(ROW_VALUE[r]);
                        FILL_RAND:  take_bits(elem);
                        default:    elem = (k % 2 == 0) ? 8'h80 : 8'h7f;
                    endcase
                    word[k*ln_geom_pkg::ELEM_W +: ln_geom_pkg::ELEM_W] = elem;
                end
                send_beat(word);
            end
        end
        @(posedge clk);
        in_vld <= 1'b0;
        wait (vec_count == NUM_ROWS);
        @(posedge clk);
        chk_done <= 1'b1;
        wait (closed);
        $display("vectors %0d, checks %0d, errors %0d", vec_count, check_count, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // run length bound from the table
    initial begin
        int max_delay;
        int limit;
        max_delay = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (ROW_DELAY[r] > max_delay) begin
                max_delay = ROW_DELAY[r];
            end
        end
        limit = 10 + NUM_ROWS * ln_geom_pkg::VEC_BEATS * (max_delay + 4) + 200;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule

//--- layer_center.f
logic/ln_geom_pkg.sv
logic/ln_flow_pkg.sv
logic/beat_buffer.sv
logic/lane_adder_tree.sv
logic/mean_unit.sv
logic/center_unit.sv
logic/variance_unit.sv
logic/ln_top.sv
bench/ln_checker.sv
bench/ln_tb.sv

//--- run.sh
#!/bin/sh
# build and run the layer_center testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f layer_center.f --top-module ln_tb -o ln_sim

out=$(./obj_dir/ln_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'sim passed'; then
    exit 0
fi
exit 1
